// ==== hdl/ps2_host.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ps2_settings.svh"

module ps2_host (
	input  wire                clk,
	input  wire                rst,
	input  wire                tx_en,
	input  wire ps2_pkg::ps2_byte_t tx_data,
	input  wire                rx_en,
	input  wire                ps2_clk_f,
	input  wire                ps2_dat_f,
	input  wire                clk_fall,
	output ps2_pkg::ps2_byte_t rx_data,
	output logic               tx_busy,
	output logic               rx_busy,
	output logic               tx_ack,
	output logic               rx_ack,
	output logic               tx_err,
	output logic               rx_err,
	output logic               clk_hold,
	output logic               dat_pull
);

	localparam int cnt_max = (`PS2_HOLD_CYCLES > `PS2_TIMEOUT_CYCLES) ?
		`PS2_HOLD_CYCLES : `PS2_TIMEOUT_CYCLES;
	localparam int cnt_w = $clog2(cnt_max + 1);

	ps2_pkg::host_state_e state;
	ps2_pkg::host_state_e state_nxt;

	logic [cnt_w-1:0] cnt;  // hold length or gap since last device edge
	logic [3:0] bit_cnt;
	logic [9:0] tx_buf;     // start, data, parity
	logic [10:0] rx_buf;
	logic rx_start;
	logic edge_timed;
	logic tx_wait;
	logic timeout;
	logic rx_ok;

	assign rx_start = rx_en && clk_fall;
	assign edge_timed = (state == ps2_pkg::hs_tx) || (state == ps2_pkg::hs_tx_ack) ||
		(state == ps2_pkg::hs_rx);
	// our own request hold is still draining out of the filtered clock
	assign tx_wait = (state == ps2_pkg::hs_tx) && (bit_cnt == 4'd0) && !ps2_clk_f;
	assign timeout = (cnt == cnt_w'(`PS2_TIMEOUT_CYCLES - 1));
	assign rx_ok = !rx_buf[0] && (^rx_buf[9:1]) && rx_buf[10];

	always_comb begin
		state_nxt = state;
		case (state)
			ps2_pkg::hs_delay: begin
				if (cnt == cnt_w'(`PS2_HOLD_CYCLES))
					state_nxt = ps2_pkg::hs_idle;
			end
			ps2_pkg::hs_idle: begin
				if (tx_en)
					state_nxt = ps2_pkg::hs_tx_req;  // send wins over receive
				else if (rx_start)
					state_nxt = ps2_pkg::hs_rx;
			end
			ps2_pkg::hs_tx_req: begin
				if (cnt == cnt_w'(`PS2_HOLD_CYCLES - 1))
					state_nxt = ps2_pkg::hs_tx;
			end
			ps2_pkg::hs_tx: begin
				if (bit_cnt == 4'(`PS2_TX_BITS))
					state_nxt = ps2_pkg::hs_tx_ack;
				else if (timeout)
					state_nxt = ps2_pkg::hs_tx_err;
			end
			ps2_pkg::hs_tx_ack: begin
				if (clk_fall)
					state_nxt = ps2_dat_f ? ps2_pkg::hs_tx_err : ps2_pkg::hs_tx_done;
				else if (timeout)
					state_nxt = ps2_pkg::hs_tx_err;
			end
			ps2_pkg::hs_rx: begin
				if (bit_cnt == 4'(`PS2_RX_BITS))
					state_nxt = ps2_pkg::hs_rx_chk;
				else if (timeout)
					state_nxt = ps2_pkg::hs_rx_err;
			end
			ps2_pkg::hs_rx_chk: begin
				state_nxt = rx_ok ? ps2_pkg::hs_rx_done : ps2_pkg::hs_rx_err;
			end
			default: begin
				state_nxt = ps2_pkg::hs_delay;  // result states, one cycle each
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ps2_pkg::hs_delay;
			cnt <= '0;
			bit_cnt <= 4'd0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state || state == ps2_pkg::hs_idle || tx_wait)
				cnt <= '0;
			else if (clk_fall && edge_timed)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			if (state == ps2_pkg::hs_idle)
				bit_cnt <= (rx_start && !tx_en) ? 4'd1 : 4'd0;  // start bit taken here
			else if (clk_fall && (state == ps2_pkg::hs_tx || state == ps2_pkg::hs_rx))
				bit_cnt <= bit_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ps2_pkg::hs_idle && tx_en)
			tx_buf <= {~(^tx_data), tx_data, 1'b0};  // odd parity
		else if (state == ps2_pkg::hs_tx && clk_fall)
			tx_buf <= {1'b1, tx_buf[9:1]};
		if (clk_fall && (state == ps2_pkg::hs_rx || (state == ps2_pkg::hs_idle && rx_en)))
			rx_buf <= {ps2_dat_f, rx_buf[10:1]};  // LSB first
	end

	assign rx_data = rx_buf[8:1];

	assign tx_busy = (state == ps2_pkg::hs_tx_req) || (state == ps2_pkg::hs_tx) ||
		(state == ps2_pkg::hs_tx_ack);
	assign rx_busy = (state == ps2_pkg::hs_rx) || (state == ps2_pkg::hs_rx_chk);
	assign tx_ack = (state == ps2_pkg::hs_tx_done);
	assign rx_ack = (state == ps2_pkg::hs_rx_done);
	assign tx_err = (state == ps2_pkg::hs_tx_err);
	assign rx_err = (state == ps2_pkg::hs_rx_err);

	// idle with receive off keeps the device inhibited
	assign clk_hold = (state == ps2_pkg::hs_delay) || (state == ps2_pkg::hs_tx_req) ||
		(state == ps2_pkg::hs_idle && !rx_en);
	assign dat_pull = (state == ps2_pkg::hs_tx) && !tx_buf[0];

endmodule

`default_nettype wire

// ==== hdl/ps2_keyboard_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_port (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     tx_en_i,
	input  wire ps2_pkg::ps2_byte_t tx_data_i,
	input  wire                     rx_en_i,
	input  wire                     ps2_clk_i,
	input  wire                     ps2_dat_i,
	output logic                    key_valid_o,
	output ps2_pkg::key_code_t      key_code_o,
	output logic                    key_release_o,
	output logic                    key_extended_o,
	output ps2_pkg::ps2_byte_t      rx_data_o,
	output logic                    rx_ack_o,
	output logic                    tx_busy_o,
	output logic                    rx_busy_o,
	output logic                    tx_ack_o,
	output logic                    tx_err_o,
	output logic                    rx_err_o,
	output logic                    ps2_clk_oe_o,
	output logic                    ps2_dat_oe_o
);

	logic ps2_clk_f;
	logic ps2_dat_f;
	logic clk_fall;

	ps2_line_sync u_line_sync (
		.clk       (clk),
		.rst       (rst),
		.ps2_clk_i (ps2_clk_i),
		.ps2_dat_i (ps2_dat_i),
		.ps2_clk_f (ps2_clk_f),
		.ps2_dat_f (ps2_dat_f),
		.clk_fall  (clk_fall)
	);

	ps2_host u_host (
		.clk       (clk),
		.rst       (rst),
		.tx_en     (tx_en_i),
		.tx_data   (tx_data_i),
		.rx_en     (rx_en_i),
		.ps2_clk_f (ps2_clk_f),
		.ps2_dat_f (ps2_dat_f),
		.clk_fall  (clk_fall),
		.rx_data   (rx_data_o),
		.tx_busy   (tx_busy_o),
		.rx_busy   (rx_busy_o),
		.tx_ack    (tx_ack_o),
		.rx_ack    (rx_ack_o),
		.tx_err    (tx_err_o),
		.rx_err    (rx_err_o),
		.clk_hold  (ps2_clk_oe_o),
		.dat_pull  (ps2_dat_oe_o)
	);

	ps2_scan_decoder u_scan_decoder (
		.clk          (clk),
		.rst          (rst),
		.rx_data      (rx_data_o),
		.rx_ack       (rx_ack_o),
		.rx_err       (rx_err_o),
		.key_valid    (key_valid_o),
		.key_code     (key_code_o),
		.key_release  (key_release_o),
		.key_extended (key_extended_o)
	);

endmodule

`default_nettype wire

// ==== hdl/ps2_line_sync.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ps2_settings.svh"

module ps2_line_sync (
	input  wire  clk,
	input  wire  rst,
	input  wire  ps2_clk_i,
	input  wire  ps2_dat_i,
	output logic ps2_clk_f,
	output logic ps2_dat_f,
	output logic clk_fall
);

	localparam int filt_w = $clog2(`PS2_FILTER_DEPTH + 1);

	logic [1:0] sync_a;  // bit 0 clock, bit 1 data
	logic [1:0] sync_b;
	logic [1:0] filt;
	logic [filt_w-1:0] stab_cnt [2];

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= 2'b11;  // idle lines float high
			sync_b <= 2'b11;
			filt <= 2'b11;
			clk_fall <= 1'b0;
			for (int i = 0; i < 2; i++) begin
				stab_cnt[i] <= '0;
			end
		end else begin
			sync_a <= {ps2_dat_i, ps2_clk_i};
			sync_b <= sync_a;
			for (int i = 0; i < 2; i++) begin
				if (sync_b[i] == filt[i]) begin
					stab_cnt[i] <= '0;  // glitch or no change
				end else if (stab_cnt[i] == filt_w'(`PS2_FILTER_DEPTH - 1)) begin
					filt[i] <= sync_b[i];
					stab_cnt[i] <= '0;
				end else begin
					stab_cnt[i] <= stab_cnt[i] + 1'b1;
				end
			end
			// same edge that takes the filtered clock to 0
			clk_fall <= filt[0] && !sync_b[0] &&
				(stab_cnt[0] == filt_w'(`PS2_FILTER_DEPTH - 1));
		end
	end

	assign ps2_clk_f = filt[0];
	assign ps2_dat_f = filt[1];

endmodule

`default_nettype wire

// ==== hdl/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

	typedef logic [7:0] ps2_byte_t;  // one byte as carried in a frame

	typedef logic [7:0] key_code_t;  // scan code with prefixes removed

	// frame engine states, encoded in reference order
	typedef enum logic [3:0] {
		hs_delay   = 4'd0,   // clock held low after a frame or reset
		hs_idle    = 4'd1,
		hs_tx_req  = 4'd2,   // clock held low to request a send
		hs_tx      = 4'd3,
		hs_tx_ack  = 4'd4,   // waiting for device ack bit
		hs_rx      = 4'd5,
		hs_rx_chk  = 4'd6,   // start, parity and stop check
		hs_tx_err  = 4'd7,
		hs_rx_err  = 4'd8,
		hs_tx_done = 4'd9,
		hs_rx_done = 4'd10
	} host_state_e;

endpackage

`default_nettype wire

// ==== hdl/ps2_scan_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_scan_decoder (
	input  wire                     clk,
	input  wire                     rst,
	input  wire ps2_pkg::ps2_byte_t rx_data,
	input  wire                     rx_ack,
	input  wire                     rx_err,
	output logic                    key_valid,
	output ps2_pkg::key_code_t      key_code,
	output logic                    key_release,
	output logic                    key_extended
);

	localparam ps2_pkg::ps2_byte_t code_ext = 8'hE0;
	localparam ps2_pkg::ps2_byte_t code_brk = 8'hF0;

	logic ext_flag;  // E0 seen since last key
	logic brk_flag;  // F0 seen since last key
	logic is_prefix;
	logic take_key;

	assign is_prefix = (rx_data == code_ext) || (rx_data == code_brk);
	assign take_key = rx_ack && !is_prefix;

	always_ff @(posedge clk) begin
		if (rst) begin
			ext_flag <= 1'b0;
			brk_flag <= 1'b0;
			key_valid <= 1'b0;
		end else begin
			key_valid <= take_key;
			if (rx_err || take_key) begin
				// a lost frame must not leave a prefix for the next key
				ext_flag <= 1'b0;
				brk_flag <= 1'b0;
			end else if (rx_ack) begin
				if (rx_data == code_ext)
					ext_flag <= 1'b1;
				else
					brk_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_key) begin
			key_code <= rx_data;
			key_release <= brk_flag;
			key_extended <= ext_flag;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ps2_settings.svh ====
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

// clk cycles of clock-low for a send request or post-frame inhibit
`define PS2_HOLD_CYCLES 200

`define PS2_TIMEOUT_CYCLES 200  // max gap between device falling edges
`define PS2_FILTER_DEPTH 3      // equal samples before a line level is taken

`define PS2_RX_BITS 11  // start, 8 data, parity, stop
`define PS2_TX_BITS 10  // stop bit not shifted

`endif

// ==== ps2_keyboard_port.f ====
+incdir+hdl
hdl/ps2_pkg.sv
hdl/ps2_line_sync.sv
hdl/ps2_host.sv
hdl/ps2_scan_decoder.sv
hdl/ps2_keyboard_port.sv
verif/ps2_device_model.sv
verif/tb_ps2_keyboard_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the PS/2 keyboard port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f ps2_keyboard_port.f \
	--top-module tb_ps2_keyboard_port \
	-o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

// ==== verif/ps2_device_model.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ps2_settings.svh"

module ps2_device_model (
	input  wire  clk,
	input  wire  ps2_clk_i,
	input  wire  ps2_dat_i,
	output logic clk_pull_o,
	output logic dat_pull_o
);

	localparam int half = 20;  // clk cycles per device clock phase
	localparam int lim = 4 * (`PS2_HOLD_CYCLES + 12 * 40);

	logic timed_out;  // set when a line wait expires

	initial begin
		clk_pull_o = 1'b0;
		dat_pull_o = 1'b0;
		timed_out = 1'b0;
	end

	task automatic wait_half();
		repeat (half) @(posedge clk);
	endtask

	// a device may only start once the host has released the clock
	task automatic wait_bus_idle();
		int run;
		int n;
		run = 0;
		for (n = 0; n < lim && run < half; n++) begin
			@(posedge clk);
			run = ps2_clk_i ? run + 1 : 0;
		end
		if (run < half)
			timed_out = 1'b1;
	endtask

	task automatic wait_level(input logic clk_lvl, input logic need_dat_low);
		int n;
		for (n = 0; n < lim && !(ps2_clk_i == clk_lvl && !(need_dat_low && ps2_dat_i)); n++)
			@(posedge clk);
		if (!(ps2_clk_i == clk_lvl && !(need_dat_low && ps2_dat_i)))
			timed_out = 1'b1;
	endtask

	task automatic send_byte(input ps2_pkg::ps2_byte_t data, input logic bad_par);
		logic [10:0] frame;
		frame = {1'b1, ~(^data) ^ bad_par, data, 1'b0};  // stop, parity, data, start
		wait_bus_idle();
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			dat_pull_o <= !frame[i];
			wait_half();
			clk_pull_o <= 1'b1;
			wait_half();
			clk_pull_o <= 1'b0;
		end
		wait_half();
		dat_pull_o <= 1'b0;
	endtask

	task automatic recv_byte(input logic no_ack, output ps2_pkg::ps2_byte_t data,
		output logic par, output logic stop);
		logic [10:1] bits;
		wait_level(1'b0, 1'b0);  // host request hold
		wait_level(1'b1, 1'b1);  // clock released with start bit low
		wait_half();
		for (int i = 1; i <= 10; i++) begin
			clk_pull_o <= 1'b1;
			wait_half();
			clk_pull_o <= 1'b0;
			wait_half();
			bits[i] = ps2_dat_i;  // read while clock is high
		end
		dat_pull_o <= !no_ack;
		wait_half();
		clk_pull_o <= 1'b1;
		wait_half();
		clk_pull_o <= 1'b0;
		dat_pull_o <= 1'b0;
		data = bits[8:1];
		par = bits[9];
		stop = bits[10];
	endtask

endmodule

`default_nettype wire

// ==== verif/tb_ps2_keyboard_port.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ps2_settings.svh"

module tb_ps2_keyboard_port;

	localparam int wait_lim = 4 * (`PS2_HOLD_CYCLES + 12 * 40);

	logic clk;
	logic rst;
	logic tx_en_i;
	logic rx_en_i;
	ps2_pkg::ps2_byte_t tx_data_i;
	logic ps2_clk;
	logic ps2_dat;
	logic dev_clk_pull;
	logic dev_dat_pull;
	logic key_valid_o;
	ps2_pkg::key_code_t key_code_o;
	logic key_release_o;
	logic key_extended_o;
	ps2_pkg::ps2_byte_t rx_data_o;
	logic rx_ack_o;
	logic tx_busy_o;
	logic rx_busy_o;
	logic tx_ack_o;
	logic tx_err_o;
	logic rx_err_o;
	logic ps2_clk_oe_o;
	logic ps2_dat_oe_o;

	int err_cnt = 0;
	int kv_cnt = 0;
	int rxa_cnt = 0;
	int rxe_cnt = 0;
	int txa_cnt = 0;
	int txe_cnt = 0;
	int hold_run = 0;  // request hold length of the current transmit
	ps2_pkg::key_code_t exp_code;
	ps2_pkg::ps2_byte_t exp_rx;
	logic exp_key;
	logic exp_rel;
	logic exp_ext;
	logic exp_rx_err;
	logic exp_tx_err;

	always #50 clk = ~clk;

	// wired-AND of host and device
	assign ps2_clk = !(ps2_clk_oe_o || dev_clk_pull);
	assign ps2_dat = !(ps2_dat_oe_o || dev_dat_pull);

	ps2_keyboard_port u_ps2_keyboard_port (
		.clk (clk), .rst (rst), .tx_en_i (tx_en_i), .tx_data_i (tx_data_i),
		.rx_en_i (rx_en_i), .ps2_clk_i (ps2_clk), .ps2_dat_i (ps2_dat),
		.key_valid_o (key_valid_o), .key_code_o (key_code_o),
		.key_release_o (key_release_o), .key_extended_o (key_extended_o),
		.rx_data_o (rx_data_o), .rx_ack_o (rx_ack_o), .tx_busy_o (tx_busy_o),
		.rx_busy_o (rx_busy_o), .tx_ack_o (tx_ack_o), .tx_err_o (tx_err_o),
		.rx_err_o (rx_err_o), .ps2_clk_oe_o (ps2_clk_oe_o), .ps2_dat_oe_o (ps2_dat_oe_o)
	);

	ps2_device_model u_dev (
		.clk (clk), .ps2_clk_i (ps2_clk), .ps2_dat_i (ps2_dat),
		.clk_pull_o (dev_clk_pull), .dat_pull_o (dev_dat_pull)
	);

	always @(posedge clk) begin
		kv_cnt <= kv_cnt + int'(key_valid_o);
		rxa_cnt <= rxa_cnt + int'(rx_ack_o);
		rxe_cnt <= rxe_cnt + int'(rx_err_o);
		txa_cnt <= txa_cnt + int'(tx_ack_o);
		txe_cnt <= txe_cnt + int'(tx_err_o);
		if (tx_en_i)
			hold_run <= 0;  // new request starts a fresh count
		else if (tx_busy_o && ps2_clk_oe_o)
			hold_run <= hold_run + 1;
	end

	// a key event only for a byte sent as a key, one cycle after its rx_ack_o
	key_follow: assert property (@(posedge clk) disable iff (rst)
		key_valid_o |-> $past(rx_ack_o) && exp_key)
		else record_mismatch("key_valid_o", 0, 1);
	code_chk: assert property (@(posedge clk) disable iff (rst)
		key_valid_o |-> key_code_o == exp_code)
		else record_mismatch("key_code_o", exp_code, key_code_o);
	rel_chk: assert property (@(posedge clk) disable iff (rst)
		key_valid_o |-> key_release_o == exp_rel)
		else record_mismatch("key_release_o", exp_rel, key_release_o);
	ext_chk: assert property (@(posedge clk) disable iff (rst)
		key_valid_o |-> key_extended_o == exp_ext)
		else record_mismatch("key_extended_o", exp_ext, key_extended_o);
	rx_data_chk: assert property (@(posedge clk) disable iff (rst)
		rx_ack_o |-> rx_data_o == exp_rx)
		else record_mismatch("rx_data_o", exp_rx, rx_data_o);
	rx_busy_chk: assert property (@(posedge clk) disable iff (rst)
		(rx_ack_o || rx_err_o) |-> $past(rx_busy_o))
		else record_mismatch("rx_busy_o", 1, 0);
	tx_busy_chk: assert property (@(posedge clk) disable iff (rst)
		(tx_ack_o || tx_err_o) |-> $past(tx_busy_o))
		else record_mismatch("tx_busy_o", 1, 0);
	rx_err_chk: assert property (@(posedge clk) disable iff (rst) rx_err_o |-> exp_rx_err)
		else record_mismatch("rx_err_o", 0, 1);
	tx_err_chk: assert property (@(posedge clk) disable iff (rst) tx_err_o |-> exp_tx_err)
		else record_mismatch("tx_err_o", 0, 1);
	tx_ack_chk: assert property (@(posedge clk) disable iff (rst) tx_ack_o |-> !exp_tx_err)
		else record_mismatch("tx_ack_o", 0, 1);
	inhibit_chk: assert property (@(posedge clk) disable iff (rst)
		!rx_en_i && !tx_busy_o && !rx_busy_o && !tx_ack_o && !tx_err_o && !rx_ack_o && !rx_err_o
		|-> ps2_clk_oe_o)
		else record_mismatch("ps2_clk_oe_o", 1, 0);
	hold_chk: assert property (@(posedge clk) disable iff (rst)
		$fell(tx_busy_o) |-> hold_run == `PS2_HOLD_CYCLES)
		else record_mismatch("ps2_clk_oe_o hold", `PS2_HOLD_CYCLES, hold_run);

	task automatic record_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		err_cnt++;
		$display("Fail %s expected %h got %h", name, exp, act);
	endtask

	task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else record_mismatch(name, exp, act);
	endtask

	task automatic stuck(input string what);
		$display("timeout while waiting for %s", what);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	function automatic int count_of(input int sel);
		case (sel)
			0: return kv_cnt;
			1: return rxa_cnt + rxe_cnt;  // any receive result
			default: return txa_cnt + txe_cnt;
		endcase
	endfunction

	task automatic wait_count(input int sel, input int target, input string what);
		for (int n = 0; n < wait_lim && count_of(sel) < target; n++)
			@(posedge clk);
		if (count_of(sel) < target)
			stuck(what);
	endtask

	task automatic wait_idle();
		for (int n = 0; n < wait_lim && (ps2_clk_oe_o || tx_busy_o || rx_busy_o); n++)
			@(posedge clk);
		if (ps2_clk_oe_o || tx_busy_o || rx_busy_o)
			stuck("host idle");
	endtask

	function automatic ps2_pkg::ps2_byte_t rand_code();
		ps2_pkg::ps2_byte_t b;
		b = 8'hE0;
		while (b == 8'hE0 || b == 8'hF0)
			b = 8'($urandom);
		return b;
	endfunction

	task automatic device_send(input ps2_pkg::ps2_byte_t b, input logic bad_par);
		int base;
		base = count_of(1);
		exp_rx = b;
		u_dev.send_byte(b, bad_par);
		if (u_dev.timed_out)
			stuck("device start");
		else
			wait_count(1, base + 1, "receive result");
	endtask

	task automatic send_key(input ps2_pkg::ps2_byte_t b, input logic rel, input logic ext);
		int k;
		k = kv_cnt;
		exp_code = b;
		exp_rel = rel;
		exp_ext = ext;
		exp_key = 1'b1;
		device_send(b, 1'b0);
		wait_count(0, k + 1, "key_valid_o");
		exp_key = 1'b0;
		repeat (3) @(posedge clk);
		check_hex("key_valid_o count", k + 1, kv_cnt);
	endtask

	task automatic do_transmit(input logic no_ack);
		ps2_pkg::ps2_byte_t d;
		ps2_pkg::ps2_byte_t got;
		logic par;
		logic stop;
		int a;
		int e;
		d = 8'($urandom);
		a = txa_cnt;
		e = txe_cnt;
		exp_tx_err = no_ack;
		fork
			u_dev.recv_byte(no_ack, got, par, stop);
			begin
				@(posedge clk);
				tx_data_i <= d;
				tx_en_i <= 1'b1;
				@(posedge clk);
				tx_en_i <= 1'b0;
			end
		join
		if (u_dev.timed_out) begin
			stuck("host request");
		end else begin
			wait_count(2, a + e + 1, "transmit result");
			check_hex("tx byte", d, got);
			check_hex("tx parity", 1, ^{got, par});
			check_hex("tx stop", 1, stop);
			check_hex("tx_ack_o count", no_ack ? a : a + 1, txa_cnt);
			check_hex("tx_err_o count", no_ack ? e + 1 : e, txe_cnt);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("%s: %s", name, (err_cnt == errs_before) ? "ok" : "errors");
	endtask

	initial begin
		int e;
		int k;
		clk = 1'b0;
		rst = 1'b1;
		tx_en_i = 1'b0;
		tx_data_i = '0;
		rx_en_i = 1'b1;
		exp_code = '0;
		exp_rx = '0;
		exp_key = 1'b0;
		exp_rel = 1'b0;
		exp_ext = 1'b0;
		exp_rx_err = 1'b0;
		exp_tx_err = 1'b0;
		void'($urandom(62));
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_hex("ps2_clk_oe_o", 1, ps2_clk_oe_o);  // reset starts in inhibit delay

		e = err_cnt;
		send_key(rand_code(), 1'b0, 1'b0);
		end_test("make code", e);

		e = err_cnt;
		device_send(8'hE0, 1'b0);
		device_send(8'hF0, 1'b0);
		send_key(rand_code(), 1'b1, 1'b1);
		end_test("extended break", e);

		e = err_cnt;
		k = kv_cnt;
		device_send(8'hE0, 1'b0);
		exp_rx_err = 1'b1;
		device_send(rand_code(), 1'b1);  // inverted parity
		check_hex("rx_err_o count", 1, rxe_cnt);
		check_hex("key_valid_o count", k, kv_cnt);
		exp_rx_err = 1'b0;
		send_key(rand_code(), 1'b0, 1'b0);  // prefix must be gone
		end_test("bad parity", e);

		e = err_cnt;
		wait_idle();
		do_transmit(1'b0);
		end_test("host transmit", e);

		e = err_cnt;
		wait_idle();
		do_transmit(1'b1);
		end_test("missing ack", e);

		e = err_cnt;
		wait_idle();
		rx_en_i <= 1'b0;
		repeat (50) @(posedge clk);
		check_hex("ps2_clk_oe_o", 1, ps2_clk_oe_o);
		do_transmit(1'b0);
		rx_en_i <= 1'b1;
		end_test("inhibit", e);

		$display("tests 6, failed checks %0d", err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
